/* design/mem_hier_pkg.sv */
`default_nettype none

package mem_hier_pkg;

    // vector types shared by every level of the hierarchy
    typedef logic [31:0]  addr_t;   // byte address
    typedef logic [31:0]  word_t;   // core data word
    typedef logic [3:0]   mask_t;   // byte enables of one word
    typedef logic [63:0]  beat_t;   // one burst beat
    typedef logic [255:0] line_t;   // one cache line

    // line geometry
    localparam int LINE_OFFSET_BITS = 5;   // 32 bytes per line
    localparam int BEATS_PER_LINE   = 4;   // 4 x 64 bit

endpackage : mem_hier_pkg

`default_nettype wire

/* design/fetch_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_cache #(
    parameter int NUM_SETS = 8
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mem_hier_pkg::addr_t addr_i,
    input  logic                read_i,
    output mem_hier_pkg::word_t rdata_o,
    output logic                resp_o,
    output mem_hier_pkg::addr_t line_addr_o,
    output logic                line_read_o,
    input  mem_hier_pkg::line_t line_rdata_i,
    input  logic                line_resp_i
);
    import mem_hier_pkg::*;

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS   = 32 - LINE_OFFSET_BITS - INDEX_BITS;

    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef enum logic [1:0] {IDLE, COMPARE, FILL} state_t;

    state_t              state_q;
    logic [NUM_SETS-1:0] valid_q;
    tag_t                tag_q  [NUM_SETS];
    line_t               line_q [NUM_SETS];

    tag_t                        addr_tag;
    index_t                      index;
    logic [LINE_OFFSET_BITS-3:0] word_sel;   // word within the line
    logic                        hit;
    logic                        serve;

    assign addr_tag    = addr_i[31 -: TAG_BITS];
    assign index       = addr_i[LINE_OFFSET_BITS +: INDEX_BITS];
    assign word_sel    = addr_i[LINE_OFFSET_BITS-1:2];
    assign hit         = valid_q[index] && (tag_q[index] == addr_tag);
    assign line_addr_o = {addr_i[31:LINE_OFFSET_BITS], LINE_OFFSET_BITS'(0)};

    // a new request is seen only once resp has dropped
    // compare answers from the freshly filled line
    assign serve = (state_q == IDLE && read_i && !resp_o && hit) || (state_q == COMPARE);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            valid_q     <= '0;
            resp_o      <= 1'b0;
            line_read_o <= 1'b0;
        end else begin
            resp_o <= serve;   // single cycle pulse
            case (state_q)
                IDLE: begin
                    if (read_i && !resp_o && !hit) begin
                        state_q     <= FILL;
                        line_read_o <= 1'b1;
                    end
                end
                FILL: begin
                    if (line_resp_i) begin
                        state_q        <= COMPARE;
                        line_read_o    <= 1'b0;
                        valid_q[index] <= 1'b1;
                    end
                end
                default: state_q <= IDLE;   // compare always hits
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (serve) rdata_o <= line_q[index][word_sel*32 +: 32];
        if (state_q == FILL && line_resp_i) begin
            line_q[index] <= line_rdata_i;
            tag_q[index]  <= addr_tag;
        end
    end

    // fill request and its address held until the arbiter answers
    assert property (@(posedge clk) disable iff (!rst_n_i)
        line_read_o && !line_resp_i |=> line_read_o && $stable(line_addr_o));

endmodule : fetch_cache

`default_nettype wire

/* design/data_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module data_cache #(
    parameter int NUM_SETS = 8
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mem_hier_pkg::addr_t addr_i,
    input  logic                read_i,
    input  logic                write_i,
    input  mem_hier_pkg::mask_t wmask_i,
    input  mem_hier_pkg::word_t wdata_i,
    output mem_hier_pkg::word_t rdata_o,
    output logic                resp_o,
    output mem_hier_pkg::addr_t line_addr_o,
    output logic                line_read_o,
    output logic                line_write_o,
    output mem_hier_pkg::line_t line_wdata_o,
    input  mem_hier_pkg::line_t line_rdata_i,
    input  logic                line_resp_i
);
    import mem_hier_pkg::*;

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS   = 32 - LINE_OFFSET_BITS - INDEX_BITS;

    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef enum logic [1:0] {IDLE, COMPARE, WRITEBACK, FILL} state_t;

    state_t              state_q;
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    tag_t                tag_q  [NUM_SETS];
    line_t               line_q [NUM_SETS];

    tag_t                        addr_tag;
    index_t                      index;
    logic [LINE_OFFSET_BITS-3:0] word_sel;
    logic                        req;
    logic                        hit;
    logic                        serve;
    line_t                       merged_line;

    assign addr_tag = addr_i[31 -: TAG_BITS];
    assign index    = addr_i[LINE_OFFSET_BITS +: INDEX_BITS];
    assign word_sel = addr_i[LINE_OFFSET_BITS-1:2];
    assign req      = read_i || write_i;
    assign hit      = valid_q[index] && (tag_q[index] == addr_tag);
    assign serve    = (state_q == IDLE && req && !resp_o && hit) || (state_q == COMPARE);

    // victim goes out at its own address during write-back
    assign line_addr_o  = (state_q == WRITEBACK) ?
                          {tag_q[index], index, LINE_OFFSET_BITS'(0)} :
                          {addr_i[31:LINE_OFFSET_BITS], LINE_OFFSET_BITS'(0)};
    assign line_wdata_o = line_q[index];

    always_comb begin
        merged_line = line_q[index];
        for (int b = 0; b < 4; b++) begin
            if (wmask_i[b]) merged_line[word_sel*32 + b*8 +: 8] = wdata_i[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            valid_q      <= '0;
            dirty_q      <= '0;
            resp_o       <= 1'b0;
            line_read_o  <= 1'b0;
            line_write_o <= 1'b0;
        end else begin
            resp_o <= serve;
            if (serve && write_i) dirty_q[index] <= 1'b1;
            case (state_q)
                IDLE: begin
                    if (req && !resp_o && !hit) begin
                        if (valid_q[index] && dirty_q[index]) begin
                            state_q      <= WRITEBACK;
                            line_write_o <= 1'b1;
                        end else begin
                            state_q     <= FILL;
                            line_read_o <= 1'b1;
                        end
                    end
                end
                WRITEBACK: begin
                    if (line_resp_i) begin
                        state_q      <= FILL;   // fill follows right away
                        line_write_o <= 1'b0;
                        line_read_o  <= 1'b1;
                    end
                end
                FILL: begin
                    if (line_resp_i) begin
                        state_q        <= COMPARE;
                        line_read_o    <= 1'b0;
                        valid_q[index] <= 1'b1;
                        dirty_q[index] <= 1'b0;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (serve) begin
            rdata_o <= line_q[index][word_sel*32 +: 32];   // pre-write word on a store
            if (write_i) line_q[index] <= merged_line;
        end
        if (state_q == FILL && line_resp_i) begin
            line_q[index] <= line_rdata_i;
            tag_q[index]  <= addr_tag;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i) !(read_i && write_i));

endmodule : data_cache

`default_nettype wire

/* design/line_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module line_arbiter (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mem_hier_pkg::addr_t if_addr_i,
    input  logic                if_read_i,
    output mem_hier_pkg::line_t if_rdata_o,
    output logic                if_resp_o,
    input  mem_hier_pkg::addr_t dc_addr_i,
    input  logic                dc_read_i,
    input  logic                dc_write_i,
    input  mem_hier_pkg::line_t dc_wdata_i,
    output mem_hier_pkg::line_t dc_rdata_o,
    output logic                dc_resp_o,
    output mem_hier_pkg::addr_t line_addr_o,
    output logic                line_read_o,
    output logic                line_write_o,
    output mem_hier_pkg::line_t line_wdata_o,
    input  mem_hier_pkg::line_t line_rdata_i,
    input  logic                line_resp_i
);
    typedef enum logic {IDLE, SERVE} state_t;

    state_t state_q;
    logic   gnt_dc_q;    // 1 when the data cache owns the grant
    logic   last_dc_q;   // winner of the last contended grant
    logic   if_req;
    logic   dc_req;
    logic   pick_dc;
    logic   serving;

    assign if_req  = if_read_i;
    assign dc_req  = dc_read_i || dc_write_i;
    assign pick_dc = dc_req && (!if_req || !last_dc_q);
    assign serving = (state_q == SERVE);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            gnt_dc_q  <= 1'b0;
            last_dc_q <= 1'b0;   // data cache wins the first tie
        end else begin
            case (state_q)
                IDLE: begin
                    if (if_req || dc_req) begin
                        state_q  <= SERVE;
                        gnt_dc_q <= pick_dc;
                        if (if_req && dc_req) last_dc_q <= pick_dc;
                    end
                end
                SERVE: if (line_resp_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    assign line_addr_o  = gnt_dc_q ? dc_addr_i : if_addr_i;
    assign line_read_o  = serving && (gnt_dc_q ? dc_read_i : if_read_i);
    assign line_write_o = serving && gnt_dc_q && dc_write_i;
    assign line_wdata_o = dc_wdata_i;   // only the data cache writes

    assign if_rdata_o = line_rdata_i;
    assign dc_rdata_o = line_rdata_i;
    assign if_resp_o  = serving && !gnt_dc_q && line_resp_i;
    assign dc_resp_o  = serving && gnt_dc_q && line_resp_i;

    // every line resp lands on exactly one requester
    assert property (@(posedge clk) disable iff (!rst_n_i)
        line_resp_i |-> serving && (if_resp_o != dc_resp_o));

endmodule : line_arbiter

`default_nettype wire

/* design/burst_adaptor.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_adaptor (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mem_hier_pkg::addr_t line_addr_i,
    input  logic                line_read_i,
    input  logic                line_write_i,
    input  mem_hier_pkg::line_t line_wdata_i,
    output mem_hier_pkg::line_t line_rdata_o,
    output logic                line_resp_o,
    output mem_hier_pkg::addr_t bmem_addr_o,
    output logic                bmem_read_o,
    output logic                bmem_write_o,
    output mem_hier_pkg::beat_t bmem_wdata_o,
    input  mem_hier_pkg::beat_t bmem_rdata_i,
    input  logic                bmem_resp_i
);
    import mem_hier_pkg::*;

    localparam int CNT_BITS  = $clog2(BEATS_PER_LINE);
    localparam int BEAT_BITS = $bits(beat_t);

    typedef enum logic {IDLE, BURST} state_t;

    state_t              state_q;
    logic [CNT_BITS-1:0] beat_cnt_q;
    line_t               shift_q;   // write data out the bottom, read data in the top
    logic                start;
    logic                last_beat;

    assign start     = (state_q == IDLE) && (line_read_i || line_write_i) && !line_resp_o;
    assign last_beat = bmem_resp_i && (beat_cnt_q == CNT_BITS'(BEATS_PER_LINE - 1));

    assign bmem_wdata_o = shift_q[BEAT_BITS-1:0];
    assign line_rdata_o = shift_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            beat_cnt_q   <= '0;
            bmem_read_o  <= 1'b0;
            bmem_write_o <= 1'b0;
            line_resp_o  <= 1'b0;
        end else begin
            line_resp_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q      <= BURST;
                        beat_cnt_q   <= '0;
                        bmem_read_o  <= line_read_i;
                        bmem_write_o <= line_write_i;
                    end
                end
                BURST: begin
                    if (bmem_resp_i) beat_cnt_q <= beat_cnt_q + 1'b1;
                    if (last_beat) begin
                        state_q      <= IDLE;
                        bmem_read_o  <= 1'b0;
                        bmem_write_o <= 1'b0;
                        line_resp_o  <= 1'b1;   // one cycle after the 4th beat
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shift_q     <= line_wdata_i;
            bmem_addr_o <= line_addr_i;
        end else if (state_q == BURST && bmem_resp_i) begin
            shift_q <= {bmem_rdata_i, shift_q[$bits(line_t)-1:BEAT_BITS]};   // lowest beat first
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i) !(bmem_read_o && bmem_write_o));

endmodule : burst_adaptor

`default_nettype wire

/* design/mem_hier_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_hier_top #(
    parameter int NUM_SETS = 8
) (
    input  logic                clk,
    input  logic                rst_n_i,
    // fetch port
    input  mem_hier_pkg::addr_t fetch_addr_i,
    input  logic                fetch_read_i,
    output mem_hier_pkg::word_t fetch_rdata_o,
    output logic                fetch_resp_o,
    // data port
    input  mem_hier_pkg::addr_t data_addr_i,
    input  logic                data_read_i,
    input  logic                data_write_i,
    input  mem_hier_pkg::mask_t data_wmask_i,
    input  mem_hier_pkg::word_t data_wdata_i,
    output mem_hier_pkg::word_t data_rdata_o,
    output logic                data_resp_o,
    // burst memory
    output mem_hier_pkg::addr_t bmem_addr_o,
    output logic                bmem_read_o,
    output logic                bmem_write_o,
    output mem_hier_pkg::beat_t bmem_wdata_o,
    input  mem_hier_pkg::beat_t bmem_rdata_i,
    input  logic                bmem_resp_i
);
    import mem_hier_pkg::*;

    addr_t if_line_addr;
    logic  if_line_read;
    line_t if_line_rdata;
    logic  if_line_resp;

    addr_t dc_line_addr;
    logic  dc_line_read;
    logic  dc_line_write;
    line_t dc_line_wdata;
    line_t dc_line_rdata;
    logic  dc_line_resp;

    addr_t line_addr;   // arbiter to adaptor
    logic  line_read;
    logic  line_write;
    line_t line_wdata;
    line_t line_rdata;
    logic  line_resp;

    fetch_cache #(.NUM_SETS(NUM_SETS)) u_fetch_cache (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .addr_i       (fetch_addr_i),
        .read_i       (fetch_read_i),
        .rdata_o      (fetch_rdata_o),
        .resp_o       (fetch_resp_o),
        .line_addr_o  (if_line_addr),
        .line_read_o  (if_line_read),
        .line_rdata_i (if_line_rdata),
        .line_resp_i  (if_line_resp)
    );

    data_cache #(.NUM_SETS(NUM_SETS)) u_data_cache (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .addr_i       (data_addr_i),
        .read_i       (data_read_i),
        .write_i      (data_write_i),
        .wmask_i      (data_wmask_i),
        .wdata_i      (data_wdata_i),
        .rdata_o      (data_rdata_o),
        .resp_o       (data_resp_o),
        .line_addr_o  (dc_line_addr),
        .line_read_o  (dc_line_read),
        .line_write_o (dc_line_write),
        .line_wdata_o (dc_line_wdata),
        .line_rdata_i (dc_line_rdata),
        .line_resp_i  (dc_line_resp)
    );

    line_arbiter u_line_arbiter (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .if_addr_i    (if_line_addr),
        .if_read_i    (if_line_read),
        .if_rdata_o   (if_line_rdata),
        .if_resp_o    (if_line_resp),
        .dc_addr_i    (dc_line_addr),
        .dc_read_i    (dc_line_read),
        .dc_write_i   (dc_line_write),
        .dc_wdata_i   (dc_line_wdata),
        .dc_rdata_o   (dc_line_rdata),
        .dc_resp_o    (dc_line_resp),
        .line_addr_o  (line_addr),
        .line_read_o  (line_read),
        .line_write_o (line_write),
        .line_wdata_o (line_wdata),
        .line_rdata_i (line_rdata),
        .line_resp_i  (line_resp)
    );

    burst_adaptor u_burst_adaptor (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .line_addr_i  (line_addr),
        .line_read_i  (line_read),
        .line_write_i (line_write),
        .line_wdata_i (line_wdata),
        .line_rdata_o (line_rdata),
        .line_resp_o  (line_resp),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o),
        .bmem_wdata_o (bmem_wdata_o),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_resp_i  (bmem_resp_i)
    );

endmodule : mem_hier_top

`default_nettype wire

/* dv/burst_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_mem_model #(
    parameter int START_DELAY = 3,
    parameter int DEPTH_BEATS = 1024
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mem_hier_pkg::addr_t addr_i,
    input  logic                read_i,
    input  logic                write_i,
    input  mem_hier_pkg::beat_t wdata_i,
    output mem_hier_pkg::beat_t rdata_o,
    output logic                resp_o
);
    import mem_hier_pkg::*;

    localparam int IDX_BITS = $clog2(DEPTH_BEATS);

    beat_t               mem [DEPTH_BEATS];
    int                  wait_q;
    logic [1:0]          beat_q;     // beat within the current burst
    logic [IDX_BITS-1:0] beat_idx;

    assign beat_idx = {addr_i[5 +: IDX_BITS-2], beat_q};   // line aligned address

    // every 32 bit word holds its byte address xor a fixed tag
    initial begin
        for (int i = 0; i < DEPTH_BEATS; i++) begin
            mem[i] = {32'(i * 8 + 4) ^ 32'hA5A5_0000, 32'(i * 8) ^ 32'hA5A5_0000};
        end
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            wait_q  <= 0;
            beat_q  <= '0;
            resp_o  <= 1'b0;
            rdata_o <= '0;
        end else begin
            resp_o <= 1'b0;
            if (resp_o) begin
                beat_q <= beat_q + 2'd1;
                if (write_i) mem[beat_idx] <= wdata_i;   // beat taken along with its resp
            end
            // one idle cycle between beats keeps the burst from being back to back
            if ((read_i || write_i) && !(resp_o && beat_q == 2'd3)) begin
                if (wait_q < START_DELAY) begin
                    wait_q <= wait_q + 1;
                end else if (!resp_o) begin
                    resp_o  <= 1'b1;
                    rdata_o <= mem[beat_idx];
                end
            end else begin
                wait_q <= 0;
            end
        end
    end

endmodule : burst_mem_model

`default_nettype wire

/* dv/mem_hier_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_hier_tb;
    import mem_hier_pkg::*;

    localparam int NUM_SETS       = 8;
    localparam int NUM_ROWS       = 20;
    localparam int CYCLES_PER_ROW = 200;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * CYCLES_PER_ROW + RESET_CYCLES;

    localparam logic [1:0] OP_NONE  = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_WRITE = 2'd2;

    typedef struct packed {
        logic       fetch;       // issue a fetch read
        addr_t      fetch_addr;
        logic [1:0] op;          // data port operation
        addr_t      data_addr;
        mask_t      wmask;
        word_t      wdata;
        logic       rand_data;   // mask and data drawn at run time
    } row_t;

    logic  clk;
    logic  rst_n;
    addr_t fetch_addr;
    logic  fetch_read;
    word_t fetch_rdata;
    logic  fetch_resp;
    addr_t data_addr;
    logic  data_read;
    logic  data_write;
    mask_t data_wmask;
    word_t data_wdata;
    word_t data_rdata;
    logic  data_resp;
    addr_t bmem_addr;
    logic  bmem_read;
    logic  bmem_write;
    beat_t bmem_wdata;
    beat_t bmem_rdata;
    logic  bmem_resp;

    row_t  rows [NUM_ROWS];
    word_t shadow [addr_t];   // words written through the data port
    int    cycle_cnt = 0;
    int    checks = 0;
    int    errors = 0;

    mem_hier_top #(.NUM_SETS(NUM_SETS)) dut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .fetch_addr_i  (fetch_addr),
        .fetch_read_i  (fetch_read),
        .fetch_rdata_o (fetch_rdata),
        .fetch_resp_o  (fetch_resp),
        .data_addr_i   (data_addr),
        .data_read_i   (data_read),
        .data_write_i  (data_write),
        .data_wmask_i  (data_wmask),
        .data_wdata_i  (data_wdata),
        .data_rdata_o  (data_rdata),
        .data_resp_o   (data_resp),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_write_o  (bmem_write),
        .bmem_wdata_o  (bmem_wdata),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_resp_i   (bmem_resp)
    );

    burst_mem_model #(.START_DELAY(3)) u_mem (
        .clk     (clk),
        .rst_n_i (rst_n),
        .addr_i  (bmem_addr),
        .read_i  (bmem_read),
        .write_i (bmem_write),
        .wdata_i (bmem_wdata),
        .rdata_o (bmem_rdata),
        .resp_o  (bmem_resp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: no response after %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    function automatic word_t expected_word(addr_t a);
        if (shadow.exists(a)) return shadow[a];
        return a ^ 32'hA5A5_0000;   // preset memory content
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, mask_t m);
        word_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) w[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return w;
    endfunction

    task automatic check_word(input string sig, input word_t got, input word_t exp);
        checks++;
        if (got === exp) begin
            $display("ok     %0t %s = %h", $time, sig, got);
        end else begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, sig, got, exp);
        end
    endtask

    // read-back of a word that went through a masked store
    task automatic check_mask_result(input string sig, input word_t got, input word_t exp);
        mask_t bad;
        bad = '0;
        for (int b = 0; b < 4; b++) begin
            bad[b] = (got[b*8 +: 8] !== exp[b*8 +: 8]);
        end
        checks++;
        if (bad == '0) begin
            $display("ok     %0t %s = %h (merged)", $time, sig, got);
        end else begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h, byte lanes %b differ",
                     $time, sig, got, exp, bad);
        end
    endtask

    task automatic check_read(input string sig, input addr_t a, input word_t got);
        if (shadow.exists(a)) check_mask_result(sig, got, expected_word(a));
        else check_word(sig, got, expected_word(a));
    endtask

    task automatic run_row(input int n);
        row_t  r;
        mask_t m;
        word_t d;
        bit    f_wait;
        bit    d_wait;
        word_t f_got;
        word_t d_got;
        r = rows[n];
        m = r.wmask;
        d = r.wdata;
        if (r.rand_data) begin
            m = mask_t'($urandom);
            d = $urandom;
        end
        f_wait = r.fetch;
        d_wait = (r.op != OP_NONE);
        @(posedge clk);
        fetch_read <= r.fetch;
        fetch_addr <= r.fetch_addr;
        data_read  <= (r.op == OP_READ);
        data_write <= (r.op == OP_WRITE);
        data_addr  <= r.data_addr;
        data_wmask <= m;
        data_wdata <= d;
        while (f_wait || d_wait) begin
            @(negedge clk);
            if (f_wait && fetch_resp) begin
                f_got  = fetch_rdata;
                f_wait = 1'b0;
            end
            if (d_wait && data_resp) begin
                d_got  = data_rdata;
                d_wait = 1'b0;
            end
            @(posedge clk);
            if (!f_wait) fetch_read <= 1'b0;   // drop in the cycle after resp
            if (!d_wait) begin
                data_read  <= 1'b0;
                data_write <= 1'b0;
            end
        end
        if (r.fetch) check_read($sformatf("row %0d fetch_rdata_o", n), r.fetch_addr, f_got);
        if (r.op == OP_READ) begin
            check_read($sformatf("row %0d data_rdata_o", n), r.data_addr, d_got);
        end else if (r.op == OP_WRITE) begin
            shadow[r.data_addr] = merge_bytes(expected_word(r.data_addr), d, m);
            $display("store  %0t row %0d addr %h mask %b data %h", $time, n, r.data_addr, m, d);
        end
    endtask

    task automatic fill_table();
        // fetch, fetch addr, data op, data addr, mask, data, random
        rows[0]  = '{1'b1, 32'h100, OP_NONE,  32'h0,   4'h0,    32'h0,         1'b0};
        rows[1]  = '{1'b1, 32'h100, OP_NONE,  32'h0,   4'h0,    32'h0,         1'b0};
        rows[2]  = '{1'b1, 32'h11C, OP_NONE,  32'h0,   4'h0,    32'h0,         1'b0};
        rows[3]  = '{1'b0, 32'h0,   OP_READ,  32'h440, 4'h0,    32'h0,         1'b0};
        rows[4]  = '{1'b0, 32'h0,   OP_READ,  32'h444, 4'h0,    32'h0,         1'b0};
        rows[5]  = '{1'b0, 32'h0,   OP_READ,  32'h45C, 4'h0,    32'h0,         1'b0};
        rows[6]  = '{1'b0, 32'h0,   OP_WRITE, 32'h448, 4'b0101, 32'h1122_3344, 1'b0};
        rows[7]  = '{1'b0, 32'h0,   OP_READ,  32'h448, 4'h0,    32'h0,         1'b0};
        rows[8]  = '{1'b0, 32'h0,   OP_WRITE, 32'h44C, 4'h0,    32'h0,         1'b1};
        rows[9]  = '{1'b0, 32'h0,   OP_READ,  32'h44C, 4'h0,    32'h0,         1'b0};
        rows[10] = '{1'b0, 32'h0,   OP_READ,  32'h840, 4'h0,    32'h0,         1'b0};  // dirty evict
        rows[11] = '{1'b0, 32'h0,   OP_READ,  32'h448, 4'h0,    32'h0,         1'b0};
        rows[12] = '{1'b1, 32'h448, OP_NONE,  32'h0,   4'h0,    32'h0,         1'b0};
        rows[13] = '{1'b1, 32'h44C, OP_NONE,  32'h0,   4'h0,    32'h0,         1'b0};
        rows[14] = '{1'b1, 32'h200, OP_WRITE, 32'h660, 4'h0,    32'h0,         1'b1};
        rows[15] = '{1'b1, 32'h284, OP_READ,  32'h660, 4'h0,    32'h0,         1'b0};
        rows[16] = '{1'b1, 32'h100, OP_WRITE, 32'hA60, 4'h0,    32'h0,         1'b1};
        rows[17] = '{1'b1, 32'h208, OP_READ,  32'hA60, 4'h0,    32'h0,         1'b0};
        rows[18] = '{1'b1, 32'h660, OP_READ,  32'h664, 4'h0,    32'h0,         1'b0};
        rows[19] = '{1'b1, 32'h11C, OP_READ,  32'hA60, 4'h0,    32'h0,         1'b0};
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        fetch_addr = '0;
        fetch_read = 1'b0;
        data_addr  = '0;
        data_read  = 1'b0;
        data_write = 1'b0;
        data_wmask = '0;
        data_wdata = '0;
        void'($urandom(69434));
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < NUM_ROWS; n++) begin
            run_row(n);
        end
        repeat (2) @(posedge clk);
        $display("rows: %0d, checks: %0d, mismatches: %0d", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : mem_hier_tb

`default_nettype wire

/* verilog.f */
design/mem_hier_pkg.sv
design/fetch_cache.sv
design/data_cache.sv
design/line_arbiter.sv
design/burst_adaptor.sv
design/mem_hier_top.sv
dv/burst_mem_model.sv
dv/mem_hier_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory hierarchy testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f verilog.f --top-module mem_hier_tb -o mem_hier_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/mem_hier_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    exit 1
fi
exit 0
